// ==== include/mipsDefines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Machine word and register file geometry
`define DATA_W      32
`define REG_ADDR_W  5
`define NUM_REGS    32

// Bus address counts words
`define WORD_ADDR_W 30

// First instruction fetched out of reset
`define RESET_PC    32'h0000_0000

`endif

// ==== logic/mipsPkg.sv ====
`include "mipsDefines.svh"

package mipsPkg;

    typedef logic [`DATA_W-1:0]      word_t;
    typedef logic [`REG_ADDR_W-1:0]  regAddr_t;
    typedef logic [`WORD_ADDR_W-1:0] wordAddr_t;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type funct field, bits 5:0
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOp_e;

    // MEM is the nearer producer, WB the one behind it
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwdSel_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_DATA,
        ARB_FETCH
    } arbState_e;

endpackage

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`include "mipsDefines.svh"

module regFile
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     we_i,
    input  regAddr_t wAddr_i,
    input  word_t    wData_i,
    input  regAddr_t rAddrA_i,
    input  regAddr_t rAddrB_i,
    output word_t    rDataA_o,
    output word_t    rDataB_o
);

    word_t regs [`NUM_REGS];
    logic  wrLive;

    assign wrLive = we_i && (wAddr_i != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wAddr_i] <= wData_i;
        end
    end

    // Same-cycle write bypass
    assign rDataA_o = (wrLive && wAddr_i == rAddrA_i) ? wData_i : regs[rAddrA_i];
    assign rDataB_o = (wrLive && wAddr_i == rAddrB_i) ? wData_i : regs[rAddrB_i];

    assert property (@(posedge clk) disable iff (rst)
        (rAddrA_i != '0 || rDataA_o == '0) && (rAddrB_i != '0 || rDataB_o == '0));

endmodule

// ==== logic/instDecoder.sv ====
`timescale 1ns/1ps
`include "mipsDefines.svh"

module instDecoder
    import mipsPkg::*;
(
    input  word_t    inst_i,
    output logic     regWrite_o,
    output logic     memRead_o,
    output logic     memWrite_o,
    output logic     aluSrcImm_o,
    output logic     beq_o,
    output logic     bne_o,
    output logic     jump_o,
    output aluOp_e   aluOp_o,
    output regAddr_t rd_o,
    output word_t    imm_o
);

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(inst_i[31:26]);
    assign funct  = funct_e'(inst_i[5:0]);

    always_comb begin
        regWrite_o  = 1'b0;
        memRead_o   = 1'b0;
        memWrite_o  = 1'b0;
        aluSrcImm_o = 1'b0;
        beq_o       = 1'b0;
        bne_o       = 1'b0;
        jump_o      = 1'b0;
        aluOp_o     = ALU_ADD;
        // I-type destination is rt
        rd_o        = inst_i[20:16];
        imm_o       = {{(`DATA_W-16){inst_i[15]}}, inst_i[15:0]};
        case (opcode)
            OP_RTYPE: begin
                rd_o       = inst_i[15:11];
                regWrite_o = 1'b1;
                case (funct)
                    FN_ADDU: aluOp_o = ALU_ADD;
                    FN_SUBU: aluOp_o = ALU_SUB;
                    FN_AND:  aluOp_o = ALU_AND;
                    FN_OR:   aluOp_o = ALU_OR;
                    FN_SLT:  aluOp_o = ALU_SLT;
                    default: regWrite_o = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                regWrite_o  = 1'b1;
                aluSrcImm_o = 1'b1;
            end
            OP_LW: begin
                regWrite_o  = 1'b1;
                memRead_o   = 1'b1;
                aluSrcImm_o = 1'b1;
            end
            OP_SW: begin
                memWrite_o  = 1'b1;
                aluSrcImm_o = 1'b1;
            end
            OP_BEQ: beq_o = 1'b1;
            OP_BNE: bne_o = 1'b1;
            OP_J: begin
                jump_o = 1'b1;
                imm_o  = {{(`DATA_W-28){1'b0}}, inst_i[25:0], 2'b00};
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu
    import mipsPkg::*;
(
    input  aluOp_e op_i,
    input  word_t  a_i,
    input  word_t  b_i,
    output word_t  res_o
);

    always_comb begin
        case (op_i)
            ALU_ADD: res_o = a_i + b_i;
            ALU_SUB: res_o = a_i - b_i;
            ALU_AND: res_o = a_i & b_i;
            ALU_OR:  res_o = a_i | b_i;
            // Signed compare
            ALU_SLT: res_o = word_t'($signed(a_i) < $signed(b_i));
            default: res_o = '0;
        endcase
    end

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ps
`include "mipsDefines.svh"

module hazardUnit
    import mipsPkg::*;
(
    input  regAddr_t idRs_i,
    input  regAddr_t idRt_i,
    input  regAddr_t exRs_i,
    input  regAddr_t exRt_i,
    input  regAddr_t exRd_i,
    input  regAddr_t memRd_i,
    input  regAddr_t wbRd_i,
    input  logic     exRegWrite_i,
    input  logic     exMemRead_i,
    input  logic     memRegWrite_i,
    input  logic     wbRegWrite_i,
    input  logic     idBranchTaken_i,
    input  logic     idJump_i,
    output fwdSel_e  idFwdA_o,
    output fwdSel_e  idFwdB_o,
    output fwdSel_e  exFwdA_o,
    output fwdSel_e  exFwdB_o,
    output logic     loadStall_o,
    output logic     flushFetch_o
);

    // Nearest producer wins, r0 is never a source
    function automatic fwdSel_e pickSrc(
        regAddr_t src,
        regAddr_t nearRd,
        logic     nearWe,
        regAddr_t farRd,
        logic     farWe
    );
        if (nearWe && nearRd != `REG_ADDR_W'd0 && nearRd == src) begin
            return FWD_MEM;
        end
        if (farWe && farRd != `REG_ADDR_W'd0 && farRd == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    // Decode compares against the execute and memory stages
    assign idFwdA_o = pickSrc(idRs_i, exRd_i, exRegWrite_i, memRd_i, memRegWrite_i);
    assign idFwdB_o = pickSrc(idRt_i, exRd_i, exRegWrite_i, memRd_i, memRegWrite_i);
    assign exFwdA_o = pickSrc(exRs_i, memRd_i, memRegWrite_i, wbRd_i, wbRegWrite_i);
    assign exFwdB_o = pickSrc(exRt_i, memRd_i, memRegWrite_i, wbRd_i, wbRegWrite_i);

    assign loadStall_o = exMemRead_i && exRd_i != `REG_ADDR_W'd0
                         && (exRd_i == idRs_i || exRd_i == idRt_i);

    assign flushFetch_o = (idBranchTaken_i || idJump_i) && !loadStall_o;

endmodule

// ==== logic/mipsPipeline.sv ====
`timescale 1ns/1ps
`include "mipsDefines.svh"

module mipsPipeline
    import mipsPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output logic      fCyc_o,
    output logic      fStb_o,
    output wordAddr_t fAdr_o,
    input  word_t     fDatR_i,
    input  logic      fAck_i,
    output logic      dCyc_o,
    output logic      dStb_o,
    output logic      dWe_o,
    output wordAddr_t dAdr_o,
    output word_t     dDatW_o,
    input  word_t     dDatR_i,
    input  logic      dAck_i
);

    word_t    pc;
    word_t    pcPlus4;
    word_t    pcNext;
    word_t    ifInst;
    logic     ifValid;

    word_t    idInst;
    word_t    idPcPlus4;
    regAddr_t idRd;
    word_t    idImm;
    word_t    idRsReg;
    word_t    idRtReg;
    word_t    idRsData;
    word_t    idRtData;
    logic     idRegWrite;
    logic     idMemRead;
    logic     idMemWrite;
    logic     idAluSrcImm;
    logic     idBeq;
    logic     idBne;
    logic     idJump;
    logic     idBranchTaken;
    aluOp_e   idAluOp;
    fwdSel_e  idFwdA;
    fwdSel_e  idFwdB;

    logic     exRegWrite;
    logic     exMemRead;
    logic     exMemWrite;
    logic     exAluSrcImm;
    aluOp_e   exAluOp;
    regAddr_t exRs;
    regAddr_t exRt;
    regAddr_t exRd;
    word_t    exRsData;
    word_t    exRtData;
    word_t    exImm;
    word_t    exRsFwd;
    word_t    exRtFwd;
    word_t    exAluRes;
    fwdSel_e  exFwdA;
    fwdSel_e  exFwdB;

    logic     memRegWrite;
    logic     memMemRead;
    logic     memMemWrite;
    regAddr_t memRd;
    word_t    memAluRes;
    word_t    memRtData;
    word_t    memResult;
    logic     dDone;
    word_t    dRdata;

    logic     wbRegWrite;
    regAddr_t wbRd;
    word_t    wbData;

    logic     loadStall;
    logic     flushFetch;
    logic     memReady;
    logic     advance;

    function automatic word_t fwdMux(fwdSel_e sel, word_t regVal, word_t memVal, word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    // Global freeze unless fetch and memory are both satisfied
    assign memReady = ifValid && (!(memMemRead || memMemWrite) || dDone);
    assign advance  = memReady && !loadStall;

    // Fetch master
    assign fCyc_o  = !ifValid;
    assign fStb_o  = !ifValid;
    assign fAdr_o  = pc[`DATA_W-1:2];
    assign pcPlus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= `RESET_PC;
            ifInst  <= '0;
            ifValid <= 1'b0;
        end else if (advance) begin
            pc      <= pcNext;
            ifValid <= 1'b0;
        end else if (fAck_i) begin
            ifInst  <= fDatR_i;
            ifValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idInst    <= '0;
            idPcPlus4 <= '0;
        end else if (advance) begin
            // Squash the slot behind a taken branch or jump
            idInst    <= flushFetch ? '0 : ifInst;
            idPcPlus4 <= pcPlus4;
        end
    end

    instDecoder decoder (
        .inst_i      (idInst),
        .regWrite_o  (idRegWrite),
        .memRead_o   (idMemRead),
        .memWrite_o  (idMemWrite),
        .aluSrcImm_o (idAluSrcImm),
        .beq_o       (idBeq),
        .bne_o       (idBne),
        .jump_o      (idJump),
        .aluOp_o     (idAluOp),
        .rd_o        (idRd),
        .imm_o       (idImm)
    );

    regFile regs (
        .clk      (clk),
        .rst      (rst),
        .we_i     (wbRegWrite),
        .wAddr_i  (wbRd),
        .wData_i  (wbData),
        .rAddrA_i (idInst[25:21]),
        .rAddrB_i (idInst[20:16]),
        .rDataA_o (idRsReg),
        .rDataB_o (idRtReg)
    );

    hazardUnit hazards (
        .idRs_i          (idInst[25:21]),
        .idRt_i          (idInst[20:16]),
        .exRs_i          (exRs),
        .exRt_i          (exRt),
        .exRd_i          (exRd),
        .memRd_i         (memRd),
        .wbRd_i          (wbRd),
        .exRegWrite_i    (exRegWrite),
        .exMemRead_i     (exMemRead),
        .memRegWrite_i   (memRegWrite),
        .wbRegWrite_i    (wbRegWrite),
        .idBranchTaken_i (idBranchTaken),
        .idJump_i        (idJump),
        .idFwdA_o        (idFwdA),
        .idFwdB_o        (idFwdB),
        .exFwdA_o        (exFwdA),
        .exFwdB_o        (exFwdB),
        .loadStall_o     (loadStall),
        .flushFetch_o    (flushFetch)
    );

    // Branch compare sees the execute result and the memory-stage result
    assign idRsData      = fwdMux(idFwdA, idRsReg, exAluRes, memResult);
    assign idRtData      = fwdMux(idFwdB, idRtReg, exAluRes, memResult);
    assign idBranchTaken = (idBeq && idRsData == idRtData) || (idBne && idRsData != idRtData);

    assign pcNext = idJump        ? {idPcPlus4[31:28], idImm[27:0]} :
                    idBranchTaken ? idPcPlus4 + {idImm[29:0], 2'b00} :
                    pcPlus4;

    assign exRsFwd = fwdMux(exFwdA, exRsData, memResult, wbData);
    assign exRtFwd = fwdMux(exFwdB, exRtData, memResult, wbData);

    alu execAlu (
        .op_i  (exAluOp),
        .a_i   (exRsFwd),
        .b_i   (exAluSrcImm ? exImm : exRtFwd),
        .res_o (exAluRes)
    );

    // Data master
    assign dCyc_o    = (memMemRead || memMemWrite) && !dDone;
    assign dStb_o    = dCyc_o;
    assign dWe_o     = memMemWrite;
    assign dAdr_o    = memAluRes[`DATA_W-1:2];
    assign dDatW_o   = memRtData;
    assign memResult = memMemRead ? dRdata : memAluRes;

    always_ff @(posedge clk) begin
        if (rst) begin
            dDone  <= 1'b0;
            dRdata <= '0;
        end else if (memReady) begin
            dDone <= 1'b0;
        end else if (dAck_i) begin
            dDone  <= 1'b1;
            dRdata <= dDatR_i;
        end
    end

    // Execute, memory and writeback registers move together
    always_ff @(posedge clk) begin
        if (rst) begin
            exRegWrite  <= 1'b0;
            exMemRead   <= 1'b0;
            exMemWrite  <= 1'b0;
            exAluSrcImm <= 1'b0;
            exAluOp     <= ALU_ADD;
            exRs        <= '0;
            exRt        <= '0;
            exRd        <= '0;
            exRsData    <= '0;
            exRtData    <= '0;
            exImm       <= '0;
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
            memRd       <= '0;
            memAluRes   <= '0;
            memRtData   <= '0;
            wbRegWrite  <= 1'b0;
            wbRd        <= '0;
            wbData      <= '0;
        end else if (memReady) begin
            // Load-use bubble drops the control bits only
            exRegWrite  <= idRegWrite && !loadStall;
            exMemRead   <= idMemRead && !loadStall;
            exMemWrite  <= idMemWrite && !loadStall;
            exAluSrcImm <= idAluSrcImm;
            exAluOp     <= idAluOp;
            exRs        <= idInst[25:21];
            exRt        <= idInst[20:16];
            exRd        <= idRd;
            exRsData    <= idRsData;
            exRtData    <= idRtData;
            exImm       <= idImm;
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            memRd       <= exRd;
            memAluRes   <= exAluRes;
            memRtData   <= exRtFwd;
            wbRegWrite  <= memRegWrite;
            wbRd        <= memRd;
            wbData      <= memResult;
        end
    end

    // Stalled data access keeps its request until acknowledged
    assert property (@(posedge clk) disable iff (rst)
        dCyc_o && !dAck_i |=> dCyc_o && $stable(dAdr_o) && $stable(dWe_o));

endmodule

// ==== logic/wbArbiter.sv ====
`timescale 1ns/1ps
`include "mipsDefines.svh"

module wbArbiter
    import mipsPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fCyc_i,
    input  logic                    fStb_i,
    input  logic [`WORD_ADDR_W-1:0] fAdr_i,
    output logic [`DATA_W-1:0]      fDatR_o,
    output logic                    fAck_o,
    input  logic                    dCyc_i,
    input  logic                    dStb_i,
    input  logic                    dWe_i,
    input  logic [`WORD_ADDR_W-1:0] dAdr_i,
    input  logic [`DATA_W-1:0]      dDatW_i,
    output logic [`DATA_W-1:0]      dDatR_o,
    output logic                    dAck_o,
    output logic                    wbCyc_o,
    output logic                    wbStb_o,
    output logic                    wbWe_o,
    output logic [`WORD_ADDR_W-1:0] wbAdr_o,
    output logic [`DATA_W-1:0]      wbDatW_o,
    input  logic [`DATA_W-1:0]      wbDatR_i,
    input  logic                    wbAck_i
);

    arbState_e state;
    arbState_e stateNext;
    logic      grantData;
    logic      grantFetch;

    // Data port has priority out of idle
    always_comb begin
        stateNext = state;
        case (state)
            ARB_IDLE: begin
                if (dCyc_i) begin
                    stateNext = ARB_DATA;
                end else if (fCyc_i) begin
                    stateNext = ARB_FETCH;
                end
            end
            ARB_DATA, ARB_FETCH: begin
                if (wbAck_i) begin
                    stateNext = ARB_IDLE;
                end
            end
            default: stateNext = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else begin
            state <= stateNext;
        end
    end

    assign grantData  = (state == ARB_DATA);
    assign grantFetch = (state == ARB_FETCH);

    assign wbCyc_o  = (grantData && dCyc_i) || (grantFetch && fCyc_i);
    assign wbStb_o  = (grantData && dStb_i) || (grantFetch && fStb_i);
    assign wbWe_o   = grantData && dWe_i;
    assign wbAdr_o  = grantData ? dAdr_i : fAdr_i;
    assign wbDatW_o = dDatW_i;

    assign fDatR_o = wbDatR_i;
    assign dDatR_o = wbDatR_i;
    assign fAck_o  = grantFetch && wbAck_i;
    assign dAck_o  = grantData && wbAck_i;

    // Instruction fetches are read-only on the shared bus
    assert property (@(posedge clk) disable iff (rst) grantFetch |-> !wbWe_o);

    // Pending cycle keeps its grant and holds the bus
    assert property (@(posedge clk) disable iff (rst)
        wbCyc_o && !wbAck_i |=> $stable(state) && wbCyc_o && $stable(wbAdr_o)
                                && $stable(wbWe_o));

endmodule

// ==== logic/mipsTop.sv ====
`timescale 1ns/1ps
`include "mipsDefines.svh"

module mipsTop
    import mipsPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    output logic                    wbCyc_o,
    output logic                    wbStb_o,
    output logic                    wbWe_o,
    output logic [`WORD_ADDR_W-1:0] wbAdr_o,
    output logic [`DATA_W-1:0]      wbDatW_o,
    input  logic [`DATA_W-1:0]      wbDatR_i,
    input  logic                    wbAck_i
);

    logic      fCyc;
    logic      fStb;
    wordAddr_t fAdr;
    word_t     fDatR;
    logic      fAck;
    logic      dCyc;
    logic      dStb;
    logic      dWe;
    wordAddr_t dAdr;
    word_t     dDatW;
    word_t     dDatR;
    logic      dAck;

    mipsPipeline core (
        .clk     (clk),
        .rst     (rst),
        .fCyc_o  (fCyc),
        .fStb_o  (fStb),
        .fAdr_o  (fAdr),
        .fDatR_i (fDatR),
        .fAck_i  (fAck),
        .dCyc_o  (dCyc),
        .dStb_o  (dStb),
        .dWe_o   (dWe),
        .dAdr_o  (dAdr),
        .dDatW_o (dDatW),
        .dDatR_i (dDatR),
        .dAck_i  (dAck)
    );

    wbArbiter arbiter (
        .clk      (clk),
        .rst      (rst),
        .fCyc_i   (fCyc),
        .fStb_i   (fStb),
        .fAdr_i   (fAdr),
        .fDatR_o  (fDatR),
        .fAck_o   (fAck),
        .dCyc_i   (dCyc),
        .dStb_i   (dStb),
        .dWe_i    (dWe),
        .dAdr_i   (dAdr),
        .dDatW_i  (dDatW),
        .dDatR_o  (dDatR),
        .dAck_o   (dAck),
        .wbCyc_o  (wbCyc_o),
        .wbStb_o  (wbStb_o),
        .wbWe_o   (wbWe_o),
        .wbAdr_o  (wbAdr_o),
        .wbDatW_o (wbDatW_o),
        .wbDatR_i (wbDatR_i),
        .wbAck_i  (wbAck_i)
    );

endmodule

// ==== verif/mipsTb.sv ====
`timescale 1ns/1ps
`include "mipsDefines.svh"

module mipsTb
    import mipsPkg::*;
;

    logic                    clk;
    logic                    rst;
    logic                    wbCyc_o;
    logic                    wbStb_o;
    logic                    wbWe_o;
    logic [`WORD_ADDR_W-1:0] wbAdr_o;
    logic [`DATA_W-1:0]      wbDatW_o;
    logic [`DATA_W-1:0]      wbDatR_i;
    logic                    wbAck_i;

    word_t     mem [256];
    string     expName [$];
    wordAddr_t expAddr [$];
    word_t     expData [$];
    int        progLines;
    int        storeIdx;
    int        passCount;
    int        failCount;
    logic      testOk;
    logic      loaded;
    logic      busy;
    logic      firstSeen;
    int        delay;

    mipsTop DUT (
        .clk      (clk),
        .rst      (rst),
        .wbCyc_o  (wbCyc_o),
        .wbStb_o  (wbStb_o),
        .wbWe_o   (wbWe_o),
        .wbAdr_o  (wbAdr_o),
        .wbDatW_o (wbDatW_o),
        .wbDatR_i (wbDatR_i),
        .wbAck_i  (wbAck_i)
    );

    always #2 clk = ~clk;

    task automatic checkAddr(string name, wordAddr_t exp, wordAddr_t act);
        if (exp !== act) begin
            $display("Error %s: address expected %h actual %h", name, exp, act);
            testOk = 1'b0;
        end
    endtask

    task automatic checkWord(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("Error %s: data expected %h actual %h", name, exp, act);
            testOk = 1'b0;
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("Error %s: bit expected %b actual %b", name, exp, act);
            testOk = 1'b0;
        end
    endtask

    task automatic closeTest(string name);
        if (testOk) begin
            passCount++;
            $display("%s: ok", name);
        end else begin
            failCount++;
            $display("%s: mismatch", name);
        end
        testOk = 1'b1;
    endtask

    task automatic loadVectors();
        int        fd;
        int        n;
        string     line;
        string     kind;
        string     name;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("verif/mipsVectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vectors file verif/mipsVectors.txt");
            failCount++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.substr(0, 0) == "P") begin
                    n = $sscanf(line, "%s %h %h", kind, a, d);
                    mem[a[7:0]] = d;
                    progLines++;
                end else if (n > 1 && line.substr(0, 0) == "E") begin
                    n = $sscanf(line, "%s %s %h %h", kind, name, a, d);
                    expName.push_back(name);
                    expAddr.push_back(wordAddr_t'(a));
                    expData.push_back(d);
                end
            end
            $fclose(fd);
        end
    endtask

    // Store checker against the next expected entry
    task automatic takeStore();
        if (storeIdx >= expAddr.size()) begin
            $display("Unexpected store to word address %h with data %h after the last expected one",
                     wbAdr_o, wbDatW_o);
            failCount++;
        end else begin
            checkAddr(expName[storeIdx], expAddr[storeIdx], wbAdr_o);
            checkWord(expName[storeIdx], expData[storeIdx], wbDatW_o);
            closeTest(expName[storeIdx]);
            storeIdx++;
        end
    endtask

    // Wishbone slave with 0 to 3 cycles of ack delay
    always begin
        @(posedge clk);
        #1;
        if (rst) begin
            wbAck_i = 1'b0;
            busy    = 1'b0;
        end else if (wbAck_i) begin
            wbAck_i  = 1'b0;
            wbDatR_i = '0;
        end else if (wbCyc_o && wbStb_o) begin
            if (!firstSeen) begin
                firstSeen = 1'b1;
                checkBit("firstFetch", 1'b0, wbWe_o);
                checkAddr("firstFetch", wordAddr_t'(`RESET_PC >> 2), wbAdr_o);
                closeTest("firstFetch");
            end
            if (!busy) begin
                busy  = 1'b1;
                delay = $urandom % 4;
            end
            if (delay == 0) begin
                busy    = 1'b0;
                wbAck_i = 1'b1;
                if (wbWe_o) begin
                    takeStore();
                    mem[wbAdr_o[7:0]] = wbDatW_o;
                end else begin
                    wbDatR_i = mem[wbAdr_o[7:0]];
                end
            end else begin
                delay--;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (progLines * 40 + 10) @(posedge clk);
        $display("Watchdog expired with %0d of %0d stores seen", storeIdx, expAddr.size());
        $display("Test failed");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        wbDatR_i  = '0;
        wbAck_i   = 1'b0;
        progLines = 0;
        storeIdx  = 0;
        passCount = 0;
        failCount = 0;
        testOk    = 1'b1;
        loaded    = 1'b0;
        busy      = 1'b0;
        firstSeen = 1'b0;
        delay     = 0;
        void'($urandom(32'h4593));
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hC0DE0000 ^ (i * 32'h0001_0101);
        end
        loadVectors();
        loaded = 1'b1;

        // Bus must stay idle while reset is held
        repeat (10) begin
            @(posedge clk);
            #1;
            checkBit("resetIdle", 1'b0, wbCyc_o);
            checkBit("resetIdle", 1'b0, wbStb_o);
            checkBit("resetIdle", 1'b0, wbWe_o);
        end
        rst = 1'b0;
        closeTest("resetIdle");

        wait (storeIdx == expAddr.size());
        // Self loop runs on so stray stores can surface
        repeat (30) @(posedge clk);

        $display("Tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== mipsTop.f ====
+incdir+include
logic/mipsPkg.sv
logic/regFile.sv
logic/instDecoder.sv
logic/alu.sv
logic/hazardUnit.sv
logic/mipsPipeline.sv
logic/wbArbiter.sv
logic/mipsTop.sv
verif/mipsTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mipsTb -f mipsTop.f \
    --Mdir build -o mipsSim

./build/mipsSim | tee sim.log

grep -q "Test completed successfully" sim.log

// ==== verif/mipsVectors.txt ====
# P <word address hex> <instruction or data word hex>
# E <test name> <store word address hex> <store data hex>
P 00 24010007
P 01 2402FFFD
P 02 00221821
P 03 AC030100
P 04 00222023
P 05 AC040104
P 06 00222824
P 07 AC050108
P 08 00223025
P 09 AC06010C
P 0A 0041382A
P 0B AC070110
P 0C 24680100
P 0D 25080001
P 0E AC080114
P 0F 8C090200
P 10 252A0010
P 11 AC0A0118
P 12 10220001
P 13 AC01011C
P 14 14220001
P 15 AC0201F0
P 16 240B0004
P 17 11630002
P 18 AC0B01F4
P 19 AC0B01F8
P 1A 14210001
P 1B AC060120
P 1C 0800001E
P 1D AC0101FC
P 1E AC080124
P 1F 0800001F
P 80 12345678
E addu 40 00000004
E subu 41 0000000A
E and 42 00000005
E or 43 FFFFFFFF
E slt 44 00000001
E fwdChain 45 00000105
E loadUse 46 12345688
E beqNotTaken 47 00000007
E bneNotTaken 48 FFFFFFFF
E jump 49 00000105
